/* rtl/l2_pkg.sv */
`default_nettype none

package l2_pkg;

    // cache geometry
    localparam int NUM_SETS = 16;
    localparam int NUM_WAYS = 2;
    localparam int INDEX_W  = $clog2(NUM_SETS);
    localparam int TAG_W    = 24;
    localparam int ADDR_W   = TAG_W + INDEX_W;
    localparam int LINE_W   = 128;

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;

    // tag in the upper bits, set index in the lower bits
    typedef logic [ADDR_W-1:0]  addr_t;

    typedef logic [LINE_W-1:0]  line_t;

    // two ways, so one bit
    typedef logic               way_t;

    typedef enum logic [1:0] {
        COMPARE,
        ALLOCATE,
        WRITE_THROUGH
    } ctrl_state_t;

endpackage

`default_nettype wire

/* rtl/set_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module set_ram #(
    parameter type payload_t = logic [7:0]
) (
    input  wire logic          clk,
    input  l2_pkg::index_t     index,
    input  wire logic          wr_en,
    input  l2_pkg::way_t       wr_way,
    input  payload_t           wdata,
    output payload_t           rd_ways [l2_pkg::NUM_WAYS]
);

    payload_t mem [l2_pkg::NUM_SETS][l2_pkg::NUM_WAYS];

    // one way of one set per cycle
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[index][wr_way] <= wdata;
        end
    end

    // whole set visible at once
    always_comb begin
        for (int w = 0; w < l2_pkg::NUM_WAYS; w++) begin
            rd_ways[w] = mem[index][w];
        end
    end

endmodule

`default_nettype wire

/* rtl/way_match.sv */
`timescale 1ns/100ps
`default_nettype none

module way_match (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  l2_pkg::index_t index,
    input  l2_pkg::tag_t   tag,
    input  l2_pkg::tag_t   tag_ways [l2_pkg::NUM_WAYS],
    input  l2_pkg::line_t  line_ways [l2_pkg::NUM_WAYS],
    input  wire logic      fill_en,
    input  l2_pkg::way_t   fill_way,
    output logic           hit,
    output l2_pkg::way_t   hit_way,
    output l2_pkg::line_t  hit_line
);

    logic [l2_pkg::NUM_WAYS-1:0] valid [l2_pkg::NUM_SETS];
    logic [l2_pkg::NUM_WAYS-1:0] way_hit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < l2_pkg::NUM_SETS; s++) begin
                valid[s] <= '0;
            end
        end else if (fill_en) begin
            valid[index][fill_way] <= 1'b1;
        end
    end

    // valid gates the compare, stale tags never match
    always_comb begin
        for (int w = 0; w < l2_pkg::NUM_WAYS; w++) begin
            way_hit[w] = valid[index][w] && (tag_ways[w] == tag);
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < l2_pkg::NUM_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_way = l2_pkg::way_t'(w);
            end
        end
    end

    assign hit      = |way_hit;
    assign hit_line = line_ways[hit_way];

    // fills only follow a miss, so a tag lives in one way at most
    a_single_hit: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(way_hit)
    );

endmodule

`default_nettype wire

/* rtl/lru_table.sv */
`timescale 1ns/100ps
`default_nettype none

module lru_table (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  l2_pkg::index_t index,
    input  wire logic      touch_en,
    input  l2_pkg::way_t   touch_way,
    output l2_pkg::way_t   victim_way
);

    // holds the least recently used way of each set
    l2_pkg::way_t lru [l2_pkg::NUM_SETS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < l2_pkg::NUM_SETS; s++) begin
                lru[s] <= 1'b0;
            end
        end else if (touch_en) begin
            // the other way becomes the next victim
            lru[index] <= ~touch_way;
        end
    end

    assign victim_way = lru[index];

    // every bit is cleared by reset, so a clean index gives a clean victim
    a_victim_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(index) |-> !$isunknown(victim_way)
    );

endmodule

`default_nettype wire

/* rtl/cache_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_ctrl (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     cache_read,
    input  wire logic     cache_write,
    input  l2_pkg::line_t cache_wdata,
    input  l2_pkg::line_t mem_rdata,
    input  wire logic     mem_ready,
    input  wire logic     hit,
    input  l2_pkg::way_t  hit_way,
    input  l2_pkg::way_t  victim_way,
    output logic          l2_ready,
    output logic          mem_read,
    output logic          mem_write,
    output logic          fill_en,
    output logic          line_we,
    output l2_pkg::way_t  line_way,
    output l2_pkg::line_t line_wdata,
    output logic          touch_en
);

    l2_pkg::ctrl_state_t state;
    l2_pkg::ctrl_state_t state_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= l2_pkg::COMPARE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        l2_ready   = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        fill_en    = 1'b0;
        line_we    = 1'b0;
        line_way   = hit_way;
        line_wdata = cache_wdata;
        touch_en   = 1'b0;

        case (state)
            l2_pkg::COMPARE: begin
                if (cache_read || cache_write) begin
                    if (!hit) begin
                        // miss, fetch the line first
                        mem_read   = 1'b1;
                        state_next = l2_pkg::ALLOCATE;
                    end else if (cache_read) begin
                        l2_ready = 1'b1;
                        touch_en = 1'b1;
                    end else begin
                        // update the hit way now, memory follows
                        line_we    = 1'b1;
                        touch_en   = 1'b1;
                        state_next = l2_pkg::WRITE_THROUGH;
                    end
                end
            end

            l2_pkg::ALLOCATE: begin
                mem_read = 1'b1;
                if (mem_ready) begin
                    fill_en    = 1'b1;
                    line_we    = 1'b1;
                    line_way   = victim_way;
                    line_wdata = mem_rdata;
                    // retry as a hit
                    state_next = l2_pkg::COMPARE;
                end
            end

            l2_pkg::WRITE_THROUGH: begin
                mem_write = 1'b1;
                if (mem_ready) begin
                    l2_ready   = 1'b1;
                    state_next = l2_pkg::COMPARE;
                end
            end

            default: begin
                state_next = l2_pkg::COMPARE;
            end
        endcase
    end

    a_mem_strobes_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(mem_read && mem_write)
    );

    a_client_strobes_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(cache_read && cache_write)
    );

endmodule

`default_nettype wire

/* rtl/l2_cache.sv */
`timescale 1ns/100ps
`default_nettype none

module l2_cache (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     cache_read,
    input  wire logic     cache_write,
    input  l2_pkg::addr_t cache_addr,
    input  l2_pkg::line_t cache_wdata,
    output l2_pkg::line_t cache_rdata,
    output logic          l2_ready,
    output logic          mem_read,
    output logic          mem_write,
    output l2_pkg::addr_t mem_addr,
    output l2_pkg::line_t mem_wdata,
    input  l2_pkg::line_t mem_rdata,
    input  wire logic     mem_ready
);

    l2_pkg::index_t index;
    l2_pkg::tag_t   tag;

    logic           hit;
    l2_pkg::way_t   hit_way;
    l2_pkg::line_t  hit_line;
    l2_pkg::way_t   victim_way;

    logic           fill_en;
    logic           line_we;
    l2_pkg::way_t   line_way;
    l2_pkg::line_t  line_wdata;
    logic           touch_en;

    l2_pkg::tag_t   tag_ways [l2_pkg::NUM_WAYS];
    l2_pkg::line_t  line_ways [l2_pkg::NUM_WAYS];

    // address split
    assign index = cache_addr[l2_pkg::INDEX_W-1:0];
    assign tag   = cache_addr[l2_pkg::ADDR_W-1:l2_pkg::INDEX_W];

    // write-through, so memory always sees the client address
    assign mem_addr    = cache_addr;
    assign cache_rdata = hit_line;
    assign mem_wdata   = hit_line;

    cache_ctrl i_cache_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .cache_read  (cache_read),
        .cache_write (cache_write),
        .cache_wdata (cache_wdata),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .l2_ready    (l2_ready),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .fill_en     (fill_en),
        .line_we     (line_we),
        .line_way    (line_way),
        .line_wdata  (line_wdata),
        .touch_en    (touch_en)
    );

    set_ram #(
        .payload_t (l2_pkg::tag_t)
    ) tag_store (
        .clk     (clk),
        .index   (index),
        .wr_en   (fill_en),
        .wr_way  (victim_way),
        .wdata   (tag),
        .rd_ways (tag_ways)
    );

    set_ram #(
        .payload_t (l2_pkg::line_t)
    ) line_store (
        .clk     (clk),
        .index   (index),
        .wr_en   (line_we),
        .wr_way  (line_way),
        .wdata   (line_wdata),
        .rd_ways (line_ways)
    );

    way_match i_way_match (
        .clk       (clk),
        .rst_n     (rst_n),
        .index     (index),
        .tag       (tag),
        .tag_ways  (tag_ways),
        .line_ways (line_ways),
        .fill_en   (fill_en),
        .fill_way  (victim_way),
        .hit       (hit),
        .hit_way   (hit_way),
        .hit_line  (hit_line)
    );

    lru_table i_lru_table (
        .clk        (clk),
        .rst_n      (rst_n),
        .index      (index),
        .touch_en   (touch_en),
        .touch_way  (hit_way),
        .victim_way (victim_way)
    );

endmodule

`default_nettype wire

/* testbench/mem_model.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_model #(
    parameter int SEED        = 1,
    parameter int MAX_LATENCY = 4
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     mem_read,
    input  wire logic     mem_write,
    input  l2_pkg::addr_t mem_addr,
    input  l2_pkg::line_t mem_wdata,
    output l2_pkg::line_t mem_rdata,
    output logic          mem_ready
);

    // only lines that were written are stored
    l2_pkg::line_t store [l2_pkg::addr_t];
    int seed;
    int lat;

    // every address bit shows up in each word
    function automatic l2_pkg::line_t pattern_line(input l2_pkg::addr_t a);
        return {{4'ha, a}, {4'h5, ~a}, {a, 4'hc}, {a[13:0], a[27:14], 4'h3}};
    endfunction

    function automatic l2_pkg::line_t read_line(input l2_pkg::addr_t a);
        if (store.exists(a)) begin
            return store[a];
        end
        return pattern_line(a);
    endfunction

    initial begin
        seed      = SEED;
        mem_ready = 1'b0;
        mem_rdata = '0;
    end

    // strobe seen at the rising edge, answer on a later falling edge
    always begin
        @(posedge clk);
        if (rst_n && (mem_read || mem_write)) begin
            lat = 1 + int'($unsigned($random(seed)) % MAX_LATENCY);
            repeat (lat) @(negedge clk);
            mem_rdata = read_line(mem_addr);
            if (mem_write) begin
                store[mem_addr] = mem_wdata;
            end
            mem_ready = 1'b1;
            @(negedge clk);
            mem_ready = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* testbench/l2_cache_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module l2_cache_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_LATENCY  = 4;
    localparam int NUM_RANDOM   = 2000;
    localparam int NUM_DIRECTED = 11;
    localparam int SEED         = 32'hd095ed47;
    localparam int WATCHDOG_NS  =
        (RESET_CYCLES + (NUM_RANDOM + NUM_DIRECTED) * (MAX_LATENCY + 4)) * CLK_PERIOD;

    // A, B and C share set 5
    localparam l2_pkg::addr_t ADDR_X = 28'h1234563;
    localparam l2_pkg::addr_t ADDR_Y = 28'h6543219;
    localparam l2_pkg::addr_t ADDR_A = 28'h00a11a5;
    localparam l2_pkg::addr_t ADDR_B = 28'h00b22b5;
    localparam l2_pkg::addr_t ADDR_C = 28'h00c33c5;
    localparam l2_pkg::line_t LINE_W1 = {4{32'hfeed0001}};
    localparam l2_pkg::line_t LINE_W2 = {4{32'h0badcafe}};

    logic          clk;
    logic          rst_n;
    logic          cache_read;
    logic          cache_write;
    l2_pkg::addr_t cache_addr;
    l2_pkg::line_t cache_wdata;
    l2_pkg::line_t cache_rdata;
    logic          l2_ready;
    logic          mem_read;
    logic          mem_write;
    l2_pkg::addr_t mem_addr;
    l2_pkg::line_t mem_wdata;
    l2_pkg::line_t mem_rdata;
    logic          mem_ready;

    // shadow of the cache state
    l2_pkg::tag_t  ref_tag [l2_pkg::NUM_SETS][l2_pkg::NUM_WAYS];
    logic          ref_valid [l2_pkg::NUM_SETS][l2_pkg::NUM_WAYS];
    l2_pkg::way_t  ref_lru [l2_pkg::NUM_SETS];
    l2_pkg::line_t ref_mem [l2_pkg::addr_t];

    l2_pkg::addr_t exp_addr_q [$];
    l2_pkg::line_t exp_line_q [$];
    logic          exp_write_q [$];
    logic          exp_fill_q [$];
    int            op_cnt;
    int            done_cnt;
    int            seen_reads;
    int            seen_writes;
    logic          last_fill;
    int            seed;

    l2_cache i_l2_cache (
        .clk         (clk),
        .rst_n       (rst_n),
        .cache_read  (cache_read),
        .cache_write (cache_write),
        .cache_addr  (cache_addr),
        .cache_wdata (cache_wdata),
        .cache_rdata (cache_rdata),
        .l2_ready    (l2_ready),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready)
    );

    mem_model #(
        .SEED        (SEED),
        .MAX_LATENCY (MAX_LATENCY)
    ) i_mem_model (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic end_with_failure();
        $display("Test FAILED");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic report_failure(input string msg);
        $display("%0t: %s", $time, msg);
        end_with_failure();
    endtask

    task automatic check_line(input string name, input l2_pkg::line_t got,
                              input l2_pkg::line_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_addr(input string name, input l2_pkg::addr_t got,
                              input l2_pkg::addr_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    // a miss fills the LRU way and the retry hit makes the other way LRU
    function automatic logic predict_hit(input l2_pkg::addr_t a);
        l2_pkg::index_t s;
        l2_pkg::tag_t   t;
        l2_pkg::way_t   w;
        logic           hit;
        s   = a[l2_pkg::INDEX_W-1:0];
        t   = a[l2_pkg::ADDR_W-1:l2_pkg::INDEX_W];
        w   = ref_lru[s];
        hit = 1'b0;
        for (int i = 0; i < l2_pkg::NUM_WAYS; i++) begin
            if (ref_valid[s][i] && ref_tag[s][i] == t) begin
                hit = 1'b1;
                w   = l2_pkg::way_t'(i);
            end
        end
        if (!hit) begin
            ref_tag[s][w]   = t;
            ref_valid[s][w] = 1'b1;
        end
        ref_lru[s] = ~w;
        return hit;
    endfunction

    task automatic run_access(input logic is_write, input l2_pkg::addr_t a,
                              input l2_pkg::line_t wdata);
        logic          hit;
        l2_pkg::line_t expected;
        hit = predict_hit(a);
        // the expected line is what memory holds
        if (is_write) begin
            ref_mem[a] = wdata;
            expected   = wdata;
        end else if (ref_mem.exists(a)) begin
            expected = ref_mem[a];
        end else begin
            expected = i_mem_model.pattern_line(a);
        end
        exp_addr_q.push_back(a);
        exp_line_q.push_back(expected);
        exp_write_q.push_back(is_write);
        exp_fill_q.push_back(!hit);
        op_cnt++;
        @(negedge clk);
        cache_read  = !is_write;
        cache_write = is_write;
        cache_addr  = a;
        cache_wdata = wdata;
        wait (done_cnt == op_cnt);
    endtask

    task automatic check_idle();
        @(negedge clk);
        cache_read  = 1'b0;
        cache_write = 1'b0;
        @(posedge clk);
        check_flag("l2_ready", l2_ready, 1'b0);
        check_flag("mem_read", mem_read, 1'b0);
        check_flag("mem_write", mem_write, 1'b0);
    endtask

    // memory traffic and completions against the queued predictions
    always @(posedge clk) begin
        if (rst_n) begin
            if (mem_ready && (mem_read || mem_write) && exp_addr_q.size() == 0) begin
                report_failure("memory transaction with no request pending");
            end else begin
                if (mem_ready && mem_read) begin
                    check_addr("mem_addr", mem_addr, exp_addr_q[0]);
                    seen_reads++;
                end
                if (mem_ready && mem_write) begin
                    check_addr("mem_addr", mem_addr, exp_addr_q[0]);
                    check_line("mem_wdata", mem_wdata, exp_line_q[0]);
                    seen_writes++;
                end
            end
            if (l2_ready && exp_addr_q.size() == 0) begin
                report_failure("l2_ready pulsed with no request pending");
            end else if (l2_ready) begin
                if (!exp_write_q[0]) begin
                    check_line("cache_rdata", cache_rdata, exp_line_q[0]);
                end
                check_flag("mem_write", mem_write, exp_write_q[0]);
                if (seen_reads != int'(exp_fill_q[0]) ||
                    seen_writes != int'(exp_write_q[0])) begin
                    report_failure($sformatf(
                        "address %h saw %0d memory reads and %0d writes, expected %0d and %0d",
                        exp_addr_q[0], seen_reads, seen_writes, exp_fill_q[0], exp_write_q[0]));
                end else begin
                    last_fill = (seen_reads != 0);
                    void'(exp_addr_q.pop_front());
                    void'(exp_line_q.pop_front());
                    void'(exp_write_q.pop_front());
                    void'(exp_fill_q.pop_front());
                    seen_reads  = 0;
                    seen_writes = 0;
                    done_cnt++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the last request completed");
        end_with_failure();
    end

    initial begin
        logic [31:0]   r;
        l2_pkg::addr_t a;
        l2_pkg::line_t d;
        seed        = SEED;
        op_cnt      = 0;
        done_cnt    = 0;
        seen_reads  = 0;
        seen_writes = 0;
        last_fill   = 1'b0;
        rst_n       = 1'b0;
        cache_read  = 1'b0;
        cache_write = 1'b0;
        cache_addr  = '0;
        cache_wdata = '0;
        for (int s = 0; s < l2_pkg::NUM_SETS; s++) begin
            ref_lru[s] = 1'b0;
            for (int w = 0; w < l2_pkg::NUM_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
            end
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        check_idle();

        run_access(1'b0, ADDR_X, '0);
        check_flag("mem_read seen", last_fill, 1'b1);
        run_access(1'b0, ADDR_X, '0);
        check_flag("mem_read seen", last_fill, 1'b0);

        // write hit followed by a read of the new line
        run_access(1'b1, ADDR_X, LINE_W1);
        check_flag("mem_read seen", last_fill, 1'b0);
        run_access(1'b0, ADDR_X, '0);

        run_access(1'b1, ADDR_Y, LINE_W2);
        check_flag("mem_read seen", last_fill, 1'b1);
        check_line("memory line", i_mem_model.read_line(ADDR_Y), LINE_W2);

        // C evicts B while A stays
        run_access(1'b0, ADDR_A, '0);
        run_access(1'b0, ADDR_B, '0);
        run_access(1'b0, ADDR_A, '0);
        run_access(1'b0, ADDR_C, '0);
        run_access(1'b0, ADDR_A, '0);
        check_flag("mem_read seen", last_fill, 1'b0);
        run_access(1'b0, ADDR_B, '0);
        check_flag("mem_read seen", last_fill, 1'b1);

        // four tags on four sets give plenty of evictions
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r = $random(seed);
            a = {22'h0b5a3c, r[1:0], 2'b00, r[3:2]};
            d = {$random(seed), $random(seed), $random(seed), $random(seed)};
            run_access(r[4], a, d);
        end

        check_idle();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
rtl/l2_pkg.sv
rtl/set_ram.sv
rtl/way_match.sv
rtl/lru_table.sv
rtl/cache_ctrl.sv
rtl/l2_cache.sv
testbench/mem_model.sv
testbench/l2_cache_tb.sv

/* Makefile */
# Verilator build and run for the L2 cache testbench

VERILATOR ?= verilator
TOP       ?= l2_cache_tb
RTL_TOP   ?= l2_cache
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only -Wall
PASS_MSG  ?= Test OK

RTL_SRCS := $(filter rtl/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the simulation prints the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
